/* bench/icache_mem_model.sv */
module icache_mem_model (
	input  logic                clk,
	input  logic                rst,
	input  logic                mem_req_valid,
	output logic                mem_req_ready,
	input  icache_pkg::addr_t   mem_req_addr,
	output logic                mem_resp_valid,
	input  logic                mem_resp_ready,
	output icache_pkg::line_t   mem_resp_line
);
	timeunit 1ns;
	timeprecision 1ps;

	// refill requests seen so far, read by the test tasks
	int req_count;
	// last line address the cache asked for
	icache_pkg::addr_t last_addr;
	// set when the cache never takes an offered line
	logic resp_timeout;
	logic [31:0] rng;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// word k at line a is a + 4k with a marker xored in
	function automatic icache_pkg::line_t line_at(input icache_pkg::addr_t a);
		icache_pkg::line_t l;
		for (int k = 0; k < 4; k++) begin
			l[32*k +: 32] = (a + 32'(4 * k)) ^ 32'hc0de_0000;
		end
		return l;
	endfunction

	initial begin
		int spins;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_line = '0;
		req_count = 0;
		last_addr = '0;
		resp_timeout = 1'b0;
		rng = 32'h5b9c;
		forever begin
			// drive on the falling edge, look 1 ns later
			@(negedge clk);
			mem_resp_valid = 1'b0;
			rng = xorshift(rng);
			// random back-pressure on the request side
			mem_req_ready = rng[0];
			#1;
			if (!rst && mem_req_valid && mem_req_ready) begin
				// request taken on the coming rising edge
				req_count++;
				last_addr = mem_req_addr;
				rng = xorshift(rng);
				// one to eight cycles until the line shows up
				repeat (int'(rng[2:0]) + 1) @(negedge clk);
				mem_req_ready = 1'b0;
				mem_resp_valid = 1'b1;
				mem_resp_line = line_at(last_addr);
				#1;
				spins = 0;
				while (!mem_resp_ready && spins < 200) begin
					spins++;
					@(negedge clk);
					#1;
				end
				// line leaves on the next rising edge
				resp_timeout = resp_timeout | !mem_resp_ready;
			end
		end
	end

endmodule

/* bench/icache_tb.sv */
module icache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_sets = 64;
	localparam int idx_w = $clog2(num_sets);
	// cycles any single wait may spin
	localparam int wait_limit = 200;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	icache_pkg::addr_t req_addr;
	logic resp_valid;
	logic resp_ready;
	icache_pkg::word_t resp_inst;
	logic invalidate;
	logic mem_req_valid;
	logic mem_req_ready;
	icache_pkg::addr_t mem_req_addr;
	logic mem_resp_valid;
	logic mem_resp_ready;
	icache_pkg::line_t mem_resp_line;

	// stall lengths for the back-pressure test
	logic [31:0] rng;

	icache_top #(
		.num_sets (num_sets)
	) u_icache_top (
		.clk            (clk),
		.rst            (rst),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.req_addr       (req_addr),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready),
		.resp_inst      (resp_inst),
		.invalidate     (invalidate),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_ready (mem_resp_ready),
		.mem_resp_line  (mem_resp_line)
	);

	icache_mem_model u_mem (
		.clk            (clk),
		.rst            (rst),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_ready (mem_resp_ready),
		.mem_resp_line  (mem_resp_line)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// memory word is its word address xored with the marker
	function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
		return {a[31:2], 2'b00} ^ 32'hc0de_0000;
	endfunction

	// clear the byte offset within the line
	function automatic icache_pkg::addr_t line_of(input icache_pkg::addr_t a);
		return a & ~((32'd1 << icache_pkg::offset_w) - 32'd1);
	endfunction

	// set 12, tag t, word w
	function automatic icache_pkg::addr_t same_set_addr(input int t, input int w);
		return (32'(t) << (icache_pkg::offset_w + idx_w)) |
			(32'd12 << icache_pkg::offset_w) | 32'(4 * w);
	endfunction

	task automatic report_failure;
		$display("Testbench failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input icache_pkg::word_t got,
		input icache_pkg::word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_line_addr(input string name, input icache_pkg::addr_t got,
		input icache_pkg::addr_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	// step to the next sample point or give up after wait_limit cycles
	task automatic step_or_timeout(inout int spins, input string what);
		spins++;
		if (spins > wait_limit) begin
			$display("timed out waiting for %s", what);
			report_failure();
		end
		@(negedge clk);
		#1;
	endtask

	task automatic apply_reset;
		@(negedge clk);
		rst = 1'b1;
		req_valid = 1'b0;
		resp_ready = 1'b0;
		invalidate = 1'b0;
		repeat (7) @(negedge clk);
		#1;
		// handshake outputs stay low while reset is held
		check_bit("req_ready", req_ready, 1'b0);
		check_bit("resp_valid", resp_valid, 1'b0);
		check_bit("mem_req_valid", mem_req_valid, 1'b0);
		check_bit("mem_resp_ready", mem_resp_ready, 1'b0);
		@(negedge clk);
		rst = 1'b0;
		// one edge out of reset and requests are taken
		@(negedge clk);
		#1;
		check_bit("req_ready", req_ready, 1'b1);
	endtask

	// one read with stall cycles of response back-pressure
	task automatic fetch(input icache_pkg::addr_t addr, input int stall,
		input logic expect_refill);
		int spins;
		int latency;
		int refills;
		icache_pkg::word_t held;
		refills = u_mem.req_count;
		@(negedge clk);
		req_valid = 1'b1;
		req_addr = addr;
		resp_ready = (stall == 0);
		#1;
		spins = 0;
		while (!req_ready) begin
			step_or_timeout(spins, "req_ready");
		end
		// accepted on the coming rising edge
		@(negedge clk);
		req_valid = 1'b0;
		#1;
		latency = 1;
		spins = 0;
		while (!resp_valid) begin
			latency++;
			step_or_timeout(spins, "resp_valid");
		end
		held = resp_inst;
		check_word("resp_inst", held, expected_word(addr));
		// a competing request during the stall must stay out
		for (int i = 0; i < stall; i++) begin
			@(negedge clk);
			req_valid = 1'b1;
			req_addr = addr ^ 32'h0000_4000;
			#1;
			check_bit("resp_valid", resp_valid, 1'b1);
			check_word("resp_inst", resp_inst, held);
			check_bit("req_ready", req_ready, 1'b0);
		end
		if (stall > 0) begin
			@(negedge clk);
			req_valid = 1'b0;
			resp_ready = 1'b1;
			#1;
			check_bit("resp_valid", resp_valid, 1'b1);
			check_word("resp_inst", resp_inst, held);
		end
		refills = u_mem.req_count - refills;
		check_bit("refill_seen", refills != 0, expect_refill);
		check_bit("extra_refill", refills > 1, 1'b0);
		check_bit("mem_resp_timeout", u_mem.resp_timeout, 1'b0);
		if (expect_refill) begin
			check_line_addr("mem_req_addr", u_mem.last_addr, line_of(addr));
		end else begin
			check_bit("hit_latency_2", latency == 2, 1'b1);
		end
	endtask

	task automatic test_cold_miss;
		fetch(32'h0000_1238, 0, 1'b1);
	endtask

	// every word of the line just filled is read twice
	task automatic test_hit;
		for (int r = 0; r < 2; r++) begin
			for (int w = 0; w < 4; w++) begin
				fetch(32'h0000_1230 | 32'(4 * w), 0, 1'b0);
			end
		end
	endtask

	task automatic test_round_robin;
		apply_reset();
		for (int t = 1; t <= 5; t++) begin
			fetch(same_set_addr(t, t % 4), 0, 1'b1);
		end
		// line 5 took way 0 from line 1
		for (int t = 2; t <= 5; t++) begin
			fetch(same_set_addr(t, 3), 0, 1'b0);
		end
		fetch(same_set_addr(1, 0), 0, 1'b1);
	endtask

	task automatic test_back_pressure;
		rng = xorshift(rng);
		fetch(same_set_addr(5, 2), int'(rng[2:0]) + 1, 1'b0);
		rng = xorshift(rng);
		fetch(32'h0002_07f4, int'(rng[2:0]) + 1, 1'b1);
	endtask

	task automatic pulse_invalidate;
		@(negedge clk);
		invalidate = 1'b1;
		#1;
		check_bit("req_ready", req_ready, 1'b0);
		@(negedge clk);
		invalidate = 1'b0;
	endtask

	task automatic test_invalidate;
		fetch(32'h0004_0a4c, 0, 1'b1);
		fetch(32'h0004_0a40, 0, 1'b0);
		pulse_invalidate();
		// valid bit gone so the line comes from memory again
		fetch(32'h0004_0a4c, 0, 1'b1);
		fetch(32'h0004_0a48, 0, 1'b0);
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		resp_ready = 1'b0;
		invalidate = 1'b0;
		rng = 32'h5b9c;
		apply_reset();
		test_cold_miss();
		test_hit();
		test_round_robin();
		test_back_pressure();
		test_invalidate();
		$display("Testbench passed");
		$finish;
	end

endmodule

/* design/icache_ctrl.sv */
module icache_ctrl #(
	parameter int num_sets = 64,
	localparam int idx_w = $clog2(num_sets),
	localparam int tag_w = icache_pkg::addr_w - idx_w - icache_pkg::offset_w
) (
	input  logic                    clk,
	input  logic                    rst,
	// fetch request
	input  logic                    req_valid,
	output logic                    req_ready,
	input  icache_pkg::addr_t       req_addr,
	// fetch response
	output logic                    resp_valid,
	input  logic                    resp_ready,
	output icache_pkg::word_t       resp_inst,
	// fence.i
	input  logic                    invalidate,
	// refill port
	output logic                    mem_req_valid,
	input  logic                    mem_req_ready,
	output icache_pkg::addr_t       mem_req_addr,
	input  logic                    mem_resp_valid,
	output logic                    mem_resp_ready,
	input  icache_pkg::line_t       mem_resp_line,
	// tag array
	output logic [idx_w-1:0]        lookup_index,
	output logic [tag_w-1:0]        lookup_tag,
	input  icache_pkg::way_mask_t   hit_mask,
	output logic                    tag_we,
	output icache_pkg::way_mask_t   tag_way_mask,
	output logic                    invalidate_all,
	// data rams
	output icache_pkg::way_mask_t   ram_en,
	output icache_pkg::way_mask_t   ram_we,
	output icache_pkg::line_t       ram_wdata,
	input  icache_pkg::line_t       ram_rdata0,
	input  icache_pkg::line_t       ram_rdata1,
	input  icache_pkg::line_t       ram_rdata2,
	input  icache_pkg::line_t       ram_rdata3
);

	icache_pkg::ctrl_state_e state;
	icache_pkg::ctrl_state_e state_next;

	// request address, held for the whole transaction
	icache_pkg::addr_t req_addr_q;

	// way that hit, zero after a miss
	icache_pkg::way_mask_t hit_way;

	// round-robin victim, one-hot
	icache_pkg::way_mask_t victim;

	// refilled line kept for the response
	icache_pkg::line_t fill_line;
	icache_pkg::line_t resp_line;

	// invalidate seen while busy, served after the response
	logic inv_pend;

	logic req_fire;
	logic refill_fire;
	logic lookup_hit;

	assign req_fire = req_valid && req_ready;
	assign refill_fire = mem_resp_valid && mem_resp_ready;
	assign lookup_hit = (state == icache_pkg::s_lookup) && (|hit_mask);

	// handshake outputs straight from state
	// reset parks in s_invalidate so req_ready stays low until released
	assign req_ready = (state == icache_pkg::s_idle) && !invalidate;
	assign resp_valid = (state == icache_pkg::s_respond);
	assign mem_req_valid = (state == icache_pkg::s_refill_req);
	assign mem_resp_ready = (state == icache_pkg::s_refill_wait);

	// refill asks for the aligned line
	assign mem_req_addr = {req_addr_q[icache_pkg::addr_w-1:icache_pkg::offset_w],
		{icache_pkg::offset_w{1'b0}}};

	assign lookup_index = req_addr_q[icache_pkg::offset_w +: idx_w];
	assign lookup_tag = req_addr_q[icache_pkg::addr_w-1 -: tag_w];

	// idle pulse clears at once, pending one via s_invalidate
	assign invalidate_all = ((state == icache_pkg::s_idle) && invalidate) ||
		(state == icache_pkg::s_invalidate);

	// tag and ram write land on the edge that accepts the line
	assign tag_we = refill_fire;
	assign tag_way_mask = victim;
	assign ram_wdata = mem_resp_line;

	always_comb begin
		ram_en = '0;
		ram_we = '0;
		if (lookup_hit) begin
			// read all ways, hit_way picks one later
			ram_en = '1;
		end else if (refill_fire) begin
			ram_en = victim;
			ram_we = victim;
		end
	end

	// next state
	always_comb begin
		state_next = state;
		case (state)
			icache_pkg::s_idle: begin
				if (req_fire) begin
					state_next = icache_pkg::s_lookup;
				end
			end
			icache_pkg::s_lookup: begin
				if (|hit_mask) begin
					state_next = icache_pkg::s_respond;
				end else begin
					state_next = icache_pkg::s_refill_req;
				end
			end
			icache_pkg::s_refill_req: begin
				// wait out memory back-pressure
				if (mem_req_ready) begin
					state_next = icache_pkg::s_refill_wait;
				end
			end
			icache_pkg::s_refill_wait: begin
				if (mem_resp_valid) begin
					state_next = icache_pkg::s_respond;
				end
			end
			icache_pkg::s_respond: begin
				if (resp_ready) begin
					if (inv_pend || invalidate) begin
						state_next = icache_pkg::s_invalidate;
					end else begin
						state_next = icache_pkg::s_idle;
					end
				end
			end
			icache_pkg::s_invalidate: begin
				state_next = icache_pkg::s_idle;
			end
			default: begin
				state_next = icache_pkg::s_idle;
			end
		endcase
	end

	// control registers
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icache_pkg::s_invalidate;
			victim <= 4'b0001;
			hit_way <= '0;
			inv_pend <= 1'b0;
		end else begin
			state <= state_next;
			// zero on a miss so the response takes fill_line
			if (state == icache_pkg::s_lookup) begin
				hit_way <= hit_mask;
			end
			// rotate once per refill, not per cycle
			if (refill_fire) begin
				victim <= {victim[2:0], victim[3]};
			end
			if (state == icache_pkg::s_invalidate) begin
				inv_pend <= 1'b0;
			end else if (invalidate && (state != icache_pkg::s_idle)) begin
				inv_pend <= 1'b1;
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (req_fire) begin
			req_addr_q <= req_addr;
		end
		if (refill_fire) begin
			fill_line <= mem_resp_line;
		end
	end

	// line source for the response
	// ram outputs hold while en is low, so this is stable in s_respond
	always_comb begin
		case (hit_way)
			4'b0001: resp_line = ram_rdata0;
			4'b0010: resp_line = ram_rdata1;
			4'b0100: resp_line = ram_rdata2;
			4'b1000: resp_line = ram_rdata3;
			default: resp_line = fill_line;
		endcase
	end

	// word select by address bits 3:2
	assign resp_inst = resp_line[32*req_addr_q[3:2] +: 32];

	// response must not change while the fetch stage stalls
	// depends on the rams holding rdata as well as on the fsm
	a_resp_hold: assert property (
		@(posedge clk) disable iff (rst)
		(resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_inst))
	);

endmodule

/* design/icache_data_ram.sv */
module icache_data_ram #(
	parameter int num_sets = 64,
	localparam int idx_w = $clog2(num_sets)
) (
	input  logic                clk,
	input  logic                en,
	input  logic                we,
	input  logic [idx_w-1:0]    index,
	input  icache_pkg::line_t   wdata,
	output icache_pkg::line_t   rdata
);

	// one line per set for this way
	icache_pkg::line_t mem [num_sets];

	// single port
	// en gates both read and write, we picks which
	// rdata only moves on a read, so it holds through a stalled response
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				// registered read, data valid the cycle after en
				rdata <= mem[index];
			end
		end
	end

endmodule

/* design/icache_pkg.sv */
package icache_pkg;

	// fetch side address width
	localparam int addr_w = 32;

	// four ways per set
	localparam int num_ways = 4;

	// 16-byte lines, so four offset bits
	localparam int offset_w = 4;

	// byte address from fetch
	typedef logic [addr_w-1:0] addr_t;

	// one instruction word
	typedef logic [31:0] word_t;

	// full line, word 0 sits in bits 31:0
	typedef logic [127:0] line_t;

	// one bit per way, used for hits, victims and ram strobes
	typedef logic [num_ways-1:0] way_mask_t;

	// controller states
	// s_invalidate is also where reset lands
	typedef enum logic [2:0] {
		s_idle,
		s_lookup,
		s_refill_req,
		s_refill_wait,
		s_respond,
		s_invalidate
	} ctrl_state_e;

endpackage

/* design/icache_tag_array.sv */
module icache_tag_array #(
	parameter int num_sets = 64,
	localparam int idx_w = $clog2(num_sets),
	localparam int tag_w = icache_pkg::addr_w - idx_w - icache_pkg::offset_w
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [idx_w-1:0]        lookup_index,
	input  logic [tag_w-1:0]        lookup_tag,
	input  logic                    tag_we,
	input  icache_pkg::way_mask_t   tag_way_mask,
	input  logic                    invalidate_all,
	output icache_pkg::way_mask_t   hit_mask
);

	// tag storage, no reset, only trusted with its valid bit
	logic [tag_w-1:0] tags [icache_pkg::num_ways][num_sets];

	// one valid vector per way, indexed by set
	logic [num_sets-1:0] valid [icache_pkg::num_ways];

	// valid bits
	// invalidate wipes every way and set in one edge
	always_ff @(posedge clk) begin
		if (rst || invalidate_all) begin
			for (int w = 0; w < icache_pkg::num_ways; w++) begin
				valid[w] <= '0;
			end
		end else if (tag_we) begin
			// only the masked way gets marked
			for (int w = 0; w < icache_pkg::num_ways; w++) begin
				if (tag_way_mask[w]) begin
					valid[w][lookup_index] <= 1'b1;
				end
			end
		end
	end

	// tag write on refill, same index as the lookup
	always_ff @(posedge clk) begin
		if (tag_we) begin
			for (int w = 0; w < icache_pkg::num_ways; w++) begin
				if (tag_way_mask[w]) begin
					tags[w][lookup_index] <= lookup_tag;
				end
			end
		end
	end

	// parallel compare across all ways
	// index and tag come from the registered request address
	always_comb begin
		for (int w = 0; w < icache_pkg::num_ways; w++) begin
			hit_mask[w] = valid[w][lookup_index] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	// a line lives in at most one way, so never two hits
	// holds only if the controller never refills a line that is present
	a_hit_onehot0: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(hit_mask)
	);

	// victim pointer from the controller must name a single way
	a_tag_we_onehot: assert property (
		@(posedge clk) disable iff (rst)
		tag_we |-> $onehot(tag_way_mask)
	);

endmodule

/* design/icache_top.sv */
module icache_top #(
	parameter int num_sets = 64,
	localparam int idx_w = $clog2(num_sets),
	localparam int tag_w = icache_pkg::addr_w - idx_w - icache_pkg::offset_w
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                req_valid,
	output logic                req_ready,
	input  icache_pkg::addr_t   req_addr,
	output logic                resp_valid,
	input  logic                resp_ready,
	output icache_pkg::word_t   resp_inst,
	input  logic                invalidate,
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	output icache_pkg::addr_t   mem_req_addr,
	input  logic                mem_resp_valid,
	output logic                mem_resp_ready,
	input  icache_pkg::line_t   mem_resp_line
);

	// controller to tag array
	logic [idx_w-1:0] lookup_index;
	logic [tag_w-1:0] lookup_tag;
	icache_pkg::way_mask_t hit_mask;
	logic tag_we;
	icache_pkg::way_mask_t tag_way_mask;
	logic invalidate_all;

	// controller to rams
	icache_pkg::way_mask_t ram_en;
	icache_pkg::way_mask_t ram_we;
	icache_pkg::line_t ram_wdata;
	icache_pkg::line_t ram_rdata0;
	icache_pkg::line_t ram_rdata1;
	icache_pkg::line_t ram_rdata2;
	icache_pkg::line_t ram_rdata3;

	icache_ctrl #(
		.num_sets (num_sets)
	) u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.req_addr       (req_addr),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready),
		.resp_inst      (resp_inst),
		.invalidate     (invalidate),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_ready (mem_resp_ready),
		.mem_resp_line  (mem_resp_line),
		.lookup_index   (lookup_index),
		.lookup_tag     (lookup_tag),
		.hit_mask       (hit_mask),
		.tag_we         (tag_we),
		.tag_way_mask   (tag_way_mask),
		.invalidate_all (invalidate_all),
		.ram_en         (ram_en),
		.ram_we         (ram_we),
		.ram_wdata      (ram_wdata),
		.ram_rdata0     (ram_rdata0),
		.ram_rdata1     (ram_rdata1),
		.ram_rdata2     (ram_rdata2),
		.ram_rdata3     (ram_rdata3)
	);

	icache_tag_array #(
		.num_sets (num_sets)
	) u_tag_array (
		.clk            (clk),
		.rst            (rst),
		.lookup_index   (lookup_index),
		.lookup_tag     (lookup_tag),
		.tag_we         (tag_we),
		.tag_way_mask   (tag_way_mask),
		.invalidate_all (invalidate_all),
		.hit_mask       (hit_mask)
	);

	// one line ram per way, all share index and write data
	icache_data_ram #(.num_sets (num_sets)) u_ram0 (
		.clk (clk), .en (ram_en[0]), .we (ram_we[0]), .index (lookup_index),
		.wdata (ram_wdata), .rdata (ram_rdata0)
	);
	icache_data_ram #(.num_sets (num_sets)) u_ram1 (
		.clk (clk), .en (ram_en[1]), .we (ram_we[1]), .index (lookup_index),
		.wdata (ram_wdata), .rdata (ram_rdata1)
	);
	icache_data_ram #(.num_sets (num_sets)) u_ram2 (
		.clk (clk), .en (ram_en[2]), .we (ram_we[2]), .index (lookup_index),
		.wdata (ram_wdata), .rdata (ram_rdata2)
	);
	icache_data_ram #(.num_sets (num_sets)) u_ram3 (
		.clk (clk), .en (ram_en[3]), .we (ram_we[3]), .index (lookup_index),
		.wdata (ram_wdata), .rdata (ram_rdata3)
	);

endmodule

/* run.sh */
#!/bin/sh
# build the icache testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
	-f verilog.f -o icache_sim || { echo "build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1
cat sim.log
# the log decides pass or fail
grep -q "Testbench failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation ok"
exit 0

/* verilog.f */
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_ram.sv
design/icache_ctrl.sv
design/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv
